// File: Makefile
TOP := tb_axil_cmd_top

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build folder"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '** PASS **'

clean:
	rm -rf obj_dir

// File: axil_cmd_top.sv
`timescale 1ns/1ns
`default_nettype none

module axil_cmd_top #(
  parameter int ADDR_W = 16,
  parameter int IRQ_W  = 8
) (
  input  wire               clk,
  input  wire               w_rst,
  // Host command
  input  wire               i_cmd_en,
  input  wire               i_cmd_wr_rd,
  input  wire  [ADDR_W-1:0] i_cmd_addr,
  input  wire  [31:0]       i_cmd_data,
  input  wire  [3:0]        i_cmd_byte_en,
  output logic              o_cmd_ack,
  output logic [31:0]       o_cmd_data,
  output logic [31:0]       o_cmd_status,
  output logic              o_cmd_interrupt,
  output logic [IRQ_W-1:0]  o_irq_vector,
  input  wire  [IRQ_W-1:0]  i_interrupts
);

  // AXI4-Lite bus
  logic [ADDR_W-1:0] awaddr;
  logic [ADDR_W-1:0] araddr;
  logic              awvalid, awready;
  logic [31:0]       wdata;
  logic [3:0]        wstrb;
  logic              wvalid, wready;
  logic [1:0]        bresp;
  logic              bvalid, bready;
  logic              arvalid, arready;
  logic [31:0]       rdata;
  logic [1:0]        rresp;
  logic              rvalid, rready;
  // Controller to datapaths
  logic              cap_cmd, cap_resp, cap_rdata;
  logic              busy;
  logic              irq_pending, irq_take;

  axil_master_ctrl u_ctrl (
    .clk(clk), .w_rst(w_rst),
    .i_cmd_en(i_cmd_en), .i_cmd_wr_rd(i_cmd_wr_rd),
    .i_awready(awready), .i_wready(wready), .i_bvalid(bvalid),
    .i_arready(arready), .i_rvalid(rvalid), .i_irq_pending(irq_pending),
    .o_awvalid(awvalid), .o_wvalid(wvalid), .o_bready(bready),
    .o_arvalid(arvalid), .o_rready(rready),
    .o_cap_cmd(cap_cmd), .o_cap_resp(cap_resp), .o_cap_rdata(cap_rdata),
    .o_busy(busy), .o_cmd_ack(o_cmd_ack),
    .o_cmd_interrupt(o_cmd_interrupt), .o_irq_take(irq_take)
  );

  axil_xfer_regs #(.ADDR_W(ADDR_W)) u_xfer (
    .clk(clk), .w_rst(w_rst),
    .i_cap_cmd(cap_cmd), .i_cap_resp(cap_resp), .i_cap_rdata(cap_rdata),
    .i_busy(busy),
    .i_cmd_addr(i_cmd_addr), .i_cmd_data(i_cmd_data), .i_cmd_byte_en(i_cmd_byte_en),
    .i_bresp(bresp), .i_rresp(rresp), .i_rdata(rdata),
    .o_awaddr(awaddr), .o_araddr(araddr), .o_wdata(wdata), .o_wstrb(wstrb),
    .o_cmd_data(o_cmd_data), .o_cmd_status(o_cmd_status)
  );

  axil_irq_collect #(.IRQ_W(IRQ_W)) u_irq (
    .clk(clk), .w_rst(w_rst),
    .i_interrupts(i_interrupts), .i_irq_take(irq_take),
    .o_irq_pending(irq_pending), .o_irq_vector(o_irq_vector)
  );

  axil_reg_slave #(.ADDR_W(ADDR_W)) u_slave (
    .clk(clk), .w_rst(w_rst),
    .i_awaddr(awaddr), .i_awvalid(awvalid), .o_awready(awready),
    .i_wdata(wdata), .i_wstrb(wstrb), .i_wvalid(wvalid), .o_wready(wready),
    .o_bresp(bresp), .o_bvalid(bvalid), .i_bready(bready),
    .i_araddr(araddr), .i_arvalid(arvalid), .o_arready(arready),
    .o_rdata(rdata), .o_rresp(rresp), .o_rvalid(rvalid), .i_rready(rready)
  );

endmodule

`default_nettype wire

// File: axil_irq_collect.sv
`timescale 1ns/1ns
`default_nettype none

module axil_irq_collect #(
  parameter int IRQ_W = 8
) (
  input  wire              clk,
  input  wire              w_rst,
  input  wire  [IRQ_W-1:0] i_interrupts,
  input  wire              i_irq_take,    // Single-cycle delivery pulse
  output logic             o_irq_pending,
  output logic [IRQ_W-1:0] o_irq_vector
);

  logic [IRQ_W-1:0] prev_q;
  logic [IRQ_W-1:0] pending_q;
  logic [IRQ_W-1:0] rise;

  assign rise          = i_interrupts & ~prev_q;  // New edges only
  assign o_irq_pending = |pending_q;

  always_ff @(posedge clk) begin
    if (w_rst) begin
      prev_q       <= '0;
      pending_q    <= '0;
      o_irq_vector <= '0;
    end else begin
      prev_q <= i_interrupts;
      if (i_irq_take) begin
        o_irq_vector <= pending_q;
        pending_q    <= rise;  // Same-cycle edge waits for next delivery
      end else begin
        pending_q <= pending_q | rise;
      end
    end
  end

endmodule

`default_nettype wire

// File: axil_master_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module axil_master_ctrl (
  input  wire  clk,
  input  wire  w_rst,
  // Host command
  input  wire  i_cmd_en,
  input  wire  i_cmd_wr_rd,     // 1 = write
  // AXI handshakes
  input  wire  i_awready,
  input  wire  i_wready,
  input  wire  i_bvalid,
  input  wire  i_arready,
  input  wire  i_rvalid,
  input  wire  i_irq_pending,
  output logic o_awvalid,
  output logic o_wvalid,
  output logic o_bready,
  output logic o_arvalid,
  output logic o_rready,
  // Datapath strobes
  output logic o_cap_cmd,
  output logic o_cap_resp,
  output logic o_cap_rdata,
  output logic o_busy,
  output logic o_cmd_ack,
  output logic o_cmd_interrupt,
  output logic o_irq_take
);

  import axil_pkg::*;

  master_state_e state;

  // Command wins over interrupt delivery
  assign o_cap_cmd   = (state == IDLE) && i_cmd_en;
  assign o_irq_take  = (state == IDLE) && !i_cmd_en && i_irq_pending;
  assign o_cap_rdata = (state == READ_DATA) && i_rvalid && o_rready;
  assign o_cap_resp  = ((state == WRITE_RESP) && i_bvalid && o_bready) || o_cap_rdata;

  assign o_busy          = (state != IDLE);
  assign o_cmd_interrupt = (state == SEND_IRQ);  // One cycle with the vector already loaded

  always_ff @(posedge clk) begin
    if (w_rst) begin
      state     <= IDLE;
      o_awvalid <= 1'b0;
      o_wvalid  <= 1'b0;
      o_bready  <= 1'b0;
      o_arvalid <= 1'b0;
      o_rready  <= 1'b0;
      o_cmd_ack <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (i_cmd_en) begin
            if (i_cmd_wr_rd) begin
              state     <= WRITE_ADDR;
              o_awvalid <= 1'b1;  // Address valid with the state change
            end else begin
              state     <= READ_ADDR;
              o_arvalid <= 1'b1;
            end
          end else if (i_irq_pending) begin
            state <= SEND_IRQ;
          end
        end
        WRITE_ADDR: begin
          if (o_awvalid && i_awready) begin
            o_awvalid <= 1'b0;
            o_wvalid  <= 1'b1;
            state     <= WRITE_DATA;
          end
        end
        WRITE_DATA: begin
          if (o_wvalid && i_wready) begin
            o_wvalid <= 1'b0;
            o_bready <= 1'b1;  // Accept response as soon as offered
            state    <= WRITE_RESP;
          end
        end
        WRITE_RESP: begin
          if (o_bready && i_bvalid) begin
            o_bready  <= 1'b0;
            o_cmd_ack <= 1'b1;
            state     <= CMD_DONE;
          end
        end
        READ_ADDR: begin
          if (o_arvalid && i_arready) begin
            o_arvalid <= 1'b0;
            o_rready  <= 1'b1;
            state     <= READ_DATA;
          end
        end
        READ_DATA: begin
          if (o_rready && i_rvalid) begin
            o_rready  <= 1'b0;
            o_cmd_ack <= 1'b1;  // Data and status land on this edge too
            state     <= CMD_DONE;
          end
        end
        CMD_DONE: begin
          // Four-phase release
          if (!i_cmd_en) begin
            o_cmd_ack <= 1'b0;
            state     <= IDLE;
          end
        end
        SEND_IRQ: state <= IDLE;
        default:  state <= IDLE;
      endcase
    end
  end

  // Valids held until accepted
  a_awvalid_hold: assert property (@(posedge clk) disable iff (w_rst)
    o_awvalid && !i_awready |=> o_awvalid);
  a_wvalid_hold: assert property (@(posedge clk) disable iff (w_rst)
    o_wvalid && !i_wready |=> o_wvalid);
  a_arvalid_hold: assert property (@(posedge clk) disable iff (w_rst)
    o_arvalid && !i_arready |=> o_arvalid);

  // Ack held through the whole of CMD_DONE
  a_done_ack: assert property (@(posedge clk) disable iff (w_rst)
    (state == CMD_DONE) |-> o_cmd_ack);
  // Ack never shown from idle
  a_ack_busy: assert property (@(posedge clk) disable iff (w_rst)
    o_cmd_ack |-> o_busy);

endmodule

`default_nettype wire

// File: axil_pkg.sv
`default_nettype none

package axil_pkg;

  // Controller states
  typedef enum logic [2:0] {
    IDLE       = 3'd0,
    WRITE_ADDR = 3'd1,  // Address phase of a write
    WRITE_DATA = 3'd2,
    WRITE_RESP = 3'd3,  // Waiting on bvalid
    READ_ADDR  = 3'd4,
    READ_DATA  = 3'd5,  // Waiting on rvalid
    CMD_DONE   = 3'd6,  // Ack held until host drops enable
    SEND_IRQ   = 3'd7
  } master_state_e;

  // AXI response codes
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_EXOKAY = 2'd1,
    RESP_SLVERR = 2'd2,
    RESP_DECERR = 2'd3
  } axi_resp_e;

  // Status word layout
  localparam int STAT_BUSY    = 0;
  localparam int STAT_ERROR   = 4;
  localparam int STAT_RESP_LO = 8;  // Response in bits 9:8

  // Slave register file
  localparam logic [31:0] ID_WORD   = 32'hA11C_0DE5;
  localparam int          REG_COUNT = 16;  // Top word is the identifier

endpackage

`default_nettype wire

// File: axil_reg_slave.sv
`timescale 1ns/1ns
`default_nettype none

module axil_reg_slave #(
  parameter int ADDR_W = 16
) (
  input  wire               clk,
  input  wire               w_rst,
  // Write address
  input  wire  [ADDR_W-1:0] i_awaddr,
  input  wire               i_awvalid,
  output logic              o_awready,
  // Write data
  input  wire  [31:0]       i_wdata,
  input  wire  [3:0]        i_wstrb,
  input  wire               i_wvalid,
  output logic              o_wready,
  // Write response
  output logic [1:0]        o_bresp,
  output logic              o_bvalid,
  input  wire               i_bready,
  // Read address
  input  wire  [ADDR_W-1:0] i_araddr,
  input  wire               i_arvalid,
  output logic              o_arready,
  // Read data
  output logic [31:0]       o_rdata,
  output logic [1:0]        o_rresp,
  output logic              o_rvalid,
  input  wire               i_rready
);

  import axil_pkg::*;

  localparam int               IDX_W  = $clog2(REG_COUNT);
  localparam logic [IDX_W-1:0] ID_IDX = IDX_W'(REG_COUNT - 1);

  logic [31:0]       regs [0:REG_COUNT-2];  // Writable words below the ID word
  logic [ADDR_W-1:0] aw_addr_q;
  logic              aw_got;                // Write address taken and data pending
  logic [IDX_W-1:0]  w_idx;
  logic [IDX_W-1:0]  r_idx;
  logic              w_dec;
  logic              r_dec;

  // Word index from bits 5:2 and window check on the bits above
  assign w_idx = aw_addr_q[IDX_W+1:2];
  assign r_idx = i_araddr[IDX_W+1:2];
  assign w_dec = |aw_addr_q[ADDR_W-1:IDX_W+2];
  assign r_dec = |i_araddr[ADDR_W-1:IDX_W+2];

  always_ff @(posedge clk) begin
    if (w_rst) begin
      o_awready <= 1'b0;
      o_wready  <= 1'b0;
      o_bvalid  <= 1'b0;
      o_arready <= 1'b0;
      o_rvalid  <= 1'b0;
      aw_got    <= 1'b0;
      for (int i = 0; i < REG_COUNT - 1; i++)
        regs[i] <= '0;
    end else begin
      // Ready one cycle after valid seen
      o_awready <= i_awvalid && !o_awready && !aw_got && !o_bvalid;
      o_wready  <= i_wvalid && !o_wready && aw_got;
      o_arready <= i_arvalid && !o_arready && !o_rvalid;

      if (i_awvalid && o_awready) begin
        aw_addr_q <= i_awaddr;
        aw_got    <= 1'b1;
      end

      if (i_wvalid && o_wready) begin
        aw_got   <= 1'b0;
        o_bvalid <= 1'b1;  // Response right after data
        if (w_dec) begin
          o_bresp <= RESP_DECERR;
        end else if (w_idx == ID_IDX) begin
          o_bresp <= RESP_SLVERR;  // ID word is read only
        end else begin
          o_bresp <= RESP_OKAY;
          for (int b = 0; b < 4; b++) begin
            if (i_wstrb[b])
              regs[w_idx][8*b +: 8] <= i_wdata[8*b +: 8];
          end
        end
      end else if (o_bvalid && i_bready) begin
        o_bvalid <= 1'b0;
      end

      if (i_arvalid && o_arready) begin
        o_rvalid <= 1'b1;
        if (r_dec) begin
          o_rresp <= RESP_DECERR;
          o_rdata <= '0;  // Nothing out of window
        end else if (r_idx == ID_IDX) begin
          o_rresp <= RESP_OKAY;
          o_rdata <= ID_WORD;
        end else begin
          o_rresp <= RESP_OKAY;
          o_rdata <= regs[r_idx];
        end
      end else if (o_rvalid && i_rready) begin
        o_rvalid <= 1'b0;
      end
    end
  end

  // Responses only follow an address transfer
  a_bvalid_cause: assert property (@(posedge clk) disable iff (w_rst)
    $rose(o_bvalid) |-> $past(aw_got));
  // Read address valid seen before ready and held through the transfer
  a_rvalid_cause: assert property (@(posedge clk) disable iff (w_rst)
    $rose(o_rvalid) |-> $past(i_arvalid) && $past(i_arvalid, 2));

endmodule

`default_nettype wire

// File: axil_xfer_regs.sv
`timescale 1ns/1ns
`default_nettype none

module axil_xfer_regs #(
  parameter int ADDR_W = 16
) (
  input  wire               clk,
  input  wire               w_rst,
  input  wire               i_cap_cmd,
  input  wire               i_cap_resp,
  input  wire               i_cap_rdata,
  input  wire               i_busy,
  // Host fields
  input  wire  [ADDR_W-1:0] i_cmd_addr,
  input  wire  [31:0]       i_cmd_data,
  input  wire  [3:0]        i_cmd_byte_en,
  // Slave responses
  input  wire  [1:0]        i_bresp,
  input  wire  [1:0]        i_rresp,
  input  wire  [31:0]       i_rdata,
  output logic [ADDR_W-1:0] o_awaddr,
  output logic [ADDR_W-1:0] o_araddr,
  output logic [31:0]       o_wdata,
  output logic [3:0]        o_wstrb,
  output logic [31:0]       o_cmd_data,
  output logic [31:0]       o_cmd_status
);

  import axil_pkg::*;

  logic [ADDR_W-1:0] addr_q;
  axi_resp_e         resp_q;
  axi_resp_e         resp_sel;
  logic              err_q;

  // One address register serves both channels
  assign o_awaddr = addr_q;
  assign o_araddr = addr_q;

  // Read path answers on rresp
  assign resp_sel = axi_resp_e'(i_cap_rdata ? i_rresp : i_bresp);

  // Command payload
  always_ff @(posedge clk) begin
    if (i_cap_cmd) begin
      addr_q  <= i_cmd_addr;
      o_wdata <= i_cmd_data;
      o_wstrb <= i_cmd_byte_en;
    end
  end

  always_ff @(posedge clk) begin
    if (w_rst) begin
      resp_q     <= RESP_OKAY;
      err_q      <= 1'b0;
      o_cmd_data <= '0;
    end else begin
      if (i_cap_cmd) begin
        resp_q <= RESP_OKAY;  // Fresh status per command
        err_q  <= 1'b0;
      end else if (i_cap_resp) begin
        resp_q <= resp_sel;
        err_q  <= (resp_sel == RESP_SLVERR) || (resp_sel == RESP_DECERR);  // Incoming code
      end
      if (i_cap_rdata)
        o_cmd_data <= i_rdata;
    end
  end

  // Status word, unused bits zero
  always_comb begin
    o_cmd_status                      = '0;
    o_cmd_status[STAT_BUSY]           = i_busy;
    o_cmd_status[STAT_ERROR]          = err_q;
    o_cmd_status[STAT_RESP_LO +: 2]   = resp_q;
  end

endmodule

`default_nettype wire

// File: sources.f
axil_pkg.sv
axil_irq_collect.sv
axil_xfer_regs.sv
axil_master_ctrl.sv
axil_reg_slave.sv
axil_cmd_top.sv
tb_axil_cmd_top.sv

// File: tb_axil_cmd_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_axil_cmd_top;

  localparam int          ADDR_W         = 16;
  localparam int          IRQ_W          = 8;
  localparam int          CMD_COUNT      = 400;
  localparam int          TIMEOUT_CYCLES = CMD_COUNT * 20 + 2000;
  localparam logic [31:0] ID_EXP         = 32'hA11C_0DE5;  // Fixed word at index 15

  logic              clk = 1'b0;
  logic              w_rst;
  logic              i_cmd_en;
  logic              i_cmd_wr_rd;
  logic [ADDR_W-1:0] i_cmd_addr;
  logic [31:0]       i_cmd_data;
  logic [3:0]        i_cmd_byte_en;
  logic [IRQ_W-1:0]  i_interrupts;
  logic              o_cmd_ack;
  logic [31:0]       o_cmd_data;
  logic [31:0]       o_cmd_status;
  logic              o_cmd_interrupt;
  logic [IRQ_W-1:0]  o_irq_vector;

  logic [31:0] rng_state   = 32'h575085a7;
  logic [31:0] model [0:15];                // Expected slave contents
  int          check_count = 0;
  int          error_count = 0;
  int          cycle_count = 0;
  int          pulse_count = 0;
  // Interrupt model state
  logic [IRQ_W-1:0] irq_prev   = '0;
  logic [IRQ_W-1:0] pend_acc   = '0;        // Edges the DUT should hold pending
  logic [IRQ_W-1:0] held_acc   = '0;        // Pending as of the previous edge
  logic [IRQ_W-1:0] held_edges = '0;
  logic             int_prev   = 1'b0;

  axil_cmd_top #(.ADDR_W(ADDR_W), .IRQ_W(IRQ_W)) u_dut (
    .clk(clk), .w_rst(w_rst),
    .i_cmd_en(i_cmd_en), .i_cmd_wr_rd(i_cmd_wr_rd), .i_cmd_addr(i_cmd_addr),
    .i_cmd_data(i_cmd_data), .i_cmd_byte_en(i_cmd_byte_en),
    .o_cmd_ack(o_cmd_ack), .o_cmd_data(o_cmd_data), .o_cmd_status(o_cmd_status),
    .o_cmd_interrupt(o_cmd_interrupt), .o_irq_vector(o_irq_vector),
    .i_interrupts(i_interrupts)
  );

  initial begin
    forever #4 clk = ~clk;  // 8 ns period
  end

  always @(posedge clk) cycle_count <= cycle_count + 1;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand_word();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("FAIL %s: got %08h, expected %08h", name, got, exp);
    end
  endtask

  task automatic check_rule(input logic ok, input string what);
    check_count++;
    assert (ok) else begin
      error_count++;
      $display("ERROR: %s", what);
    end
  endtask

  // Occasional new interrupt levels, rising and falling
  task automatic poke_irq();
    logic [31:0] r;
    r = rand_word();
    if (r[2:0] == 3'd0)
      i_interrupts = r[15:8];
  endtask

  // One host command, full four-phase cycle, called at a falling edge
  task automatic run_cmd(input logic wr, input logic [ADDR_W-1:0] addr,
                         input logic [31:0] data, input logic [3:0] be);
    logic [3:0]  idx;
    logic        dec;
    logic [1:0]  exp_resp;
    logic [31:0] exp_rdata;
    logic [31:0] exp_status;
    idx       = addr[5:2];   // Bits 1:0 ignored
    dec       = |addr[ADDR_W-1:6];
    exp_rdata = 32'h0;
    if (dec)
      exp_resp = 2'd3;       // DECERR
    else if (wr && idx == 4'd15)
      exp_resp = 2'd2;       // SLVERR, identifier is read only
    else
      exp_resp = 2'd0;
    if (!wr && !dec)
      exp_rdata = model[idx];
    if (wr && exp_resp == 2'd0) begin
      for (int b = 0; b < 4; b++) begin
        if (be[b])
          model[idx][8*b +: 8] = data[8*b +: 8];  // Strobe merge
      end
    end
    exp_status         = 32'h0;
    exp_status[0]      = 1'b1;           // Busy while acknowledged
    exp_status[4]      = exp_resp[1];    // Error on SLVERR or DECERR
    exp_status[9:8]    = exp_resp;

    i_cmd_wr_rd   = wr;
    i_cmd_addr    = addr;
    i_cmd_data    = data;
    i_cmd_byte_en = be;
    i_cmd_en      = 1'b1;
    while (!o_cmd_ack) begin
      @(negedge clk);
      poke_irq();
    end
    compare_word("o_cmd_status", o_cmd_status, exp_status);
    if (!wr)
      compare_word("o_cmd_data", o_cmd_data, exp_rdata);

    i_cmd_en = 1'b0;         // Release
    while (o_cmd_ack) begin
      @(negedge clk);
      poke_irq();
    end
    exp_status[0] = 1'b0;    // Back in idle, result fields kept
    compare_word("o_cmd_status after release", o_cmd_status, exp_status);
  endtask

  // Interrupt checker, samples at the rising edge
  always @(posedge clk) begin : irq_monitor
    logic [IRQ_W-1:0] edges;
    logic [IRQ_W-1:0] acc_next;
    if (w_rst) begin
      irq_prev   = '0;
      pend_acc   = '0;
      held_acc   = '0;
      held_edges = '0;
      int_prev   = 1'b0;
    end else begin
      edges    = i_interrupts & ~irq_prev;
      irq_prev = i_interrupts;
      if (o_cmd_interrupt) begin
        // Take happened one edge earlier
        pulse_count++;
        compare_word("o_irq_vector", 32'(o_irq_vector), 32'(held_acc));
        check_rule(!int_prev, "interrupt pulse lasted more than one cycle");
        check_rule(!o_cmd_ack, "interrupt pulse while command acknowledge was high");
        acc_next = held_edges | edges;
      end else begin
        acc_next = pend_acc | edges;
      end
      held_acc   = pend_acc;
      held_edges = edges;
      pend_acc   = acc_next;
      int_prev   = o_cmd_interrupt;
    end
  end

  initial begin
    logic [31:0]       r;
    logic [31:0]       d;
    logic [ADDR_W-1:0] addr;
    logic [9:0]        hi;
    logic [3:0]        idx;
    int                gap;
    w_rst         = 1'b1;
    i_cmd_en      = 1'b0;
    i_cmd_wr_rd   = 1'b0;
    i_cmd_addr    = '0;
    i_cmd_data    = '0;
    i_cmd_byte_en = '0;
    i_interrupts  = '0;
    for (int i = 0; i < 15; i++)
      model[i] = 32'h0;
    model[15] = ID_EXP;

    repeat (5) @(negedge clk);
    w_rst = 1'b0;
    @(negedge clk);
    compare_word("o_cmd_ack at reset", 32'(o_cmd_ack), 32'h0);
    compare_word("o_cmd_interrupt at reset", 32'(o_cmd_interrupt), 32'h0);
    compare_word("o_cmd_status at reset", o_cmd_status, 32'h0);
    compare_word("o_cmd_data at reset", o_cmd_data, 32'h0);
    compare_word("o_irq_vector at reset", 32'(o_irq_vector), 32'h0);

    for (int n = 0; n < CMD_COUNT; n++) begin
      r = rand_word();
      d = rand_word();
      if (r[11:8] < 4'd2) begin
        hi = r[25:16];
        if (hi == 10'h0)
          hi = 10'h001;            // Force out of window
        addr = {hi, d[5:0]};
      end else if (r[11:8] == 4'd2) begin
        addr = {10'h0, 4'd15, r[13:12]};
      end else begin
        idx  = 4'(r[15:12] % 4'd15);
        addr = {10'h0, idx, r[17:16]};
      end
      run_cmd(r[0], addr, rand_word(), r[7:4]);
      gap = int'(r[29:28]);        // Idle room for interrupt delivery
      repeat (gap) begin
        @(negedge clk);
        poke_irq();
      end
    end

    // Quiet window, everything pending gets delivered
    repeat (12) @(negedge clk);
    check_rule(pend_acc == '0, "interrupt edges were never delivered");
    check_rule(pulse_count > 0, "no interrupt pulse was seen");

    $display("Checks: %0d  errors: %0d  interrupt pulses: %0d",
             check_count, error_count, pulse_count);
    if (error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire
